//--- common/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry
    localparam int num_sets  = 256;
    localparam int num_banks = 4;
    localparam int num_ways  = 2;
    localparam int word_w    = 32;
    localparam int byte_w    = 8;
    localparam int lfsr_w    = 8;

    typedef logic [19:0] tag_t;
    typedef logic [7:0]  index_t;
    typedef logic [3:0]  offset_t;
    typedef logic [1:0]  bank_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [word_w/byte_w-1:0] strb_t;
    typedef logic [word_w*num_banks-1:0] line_t;
    typedef logic [31:0] addr_t;

    // Processor request, op set for a store
    typedef struct packed {
        logic    op;
        tag_t    tag;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } way_meta_t;

    // One pending store hit
    typedef struct packed {
        logic    way;
        index_t  index;
        offset_t offset;
        strb_t   wstrb;
        word_t   wdata;
    } wb_entry_t;

    // Line write towards memory
    typedef struct packed {
        addr_t addr;
        line_t data;
    } mem_wr_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss,
        st_replace,
        st_refill
    } main_state_t;

endpackage

//--- store/way_store.sv
`timescale 1ns/1ps

module way_store (
    input  logic                  clk_g,
    input  logic                  resetn,
    input  logic                  rd_en,
    input  dcache_pkg::index_t    rd_index,
    output dcache_pkg::way_meta_t meta,
    output dcache_pkg::line_t     line,
    input  logic                  wb_en,
    input  dcache_pkg::index_t    wb_index,
    input  dcache_pkg::offset_t   wb_offset,
    input  dcache_pkg::strb_t     wb_wstrb,
    input  dcache_pkg::word_t     wb_wdata,
    input  logic                  fill_en,
    input  dcache_pkg::index_t    fill_index,
    input  dcache_pkg::tag_t      fill_tag,
    input  logic                  fill_dirty,
    input  dcache_pkg::line_t     fill_line
);
    import dcache_pkg::*;

    tag_t                tag_mem [num_sets];
    word_t               data_mem [num_sets][num_banks];
    logic [num_sets-1:0] valid_q;
    logic [num_sets-1:0] dirty_q;

    // Valid and dirty flags
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_index] <= 1'b1;
            dirty_q[fill_index] <= fill_dirty;
        end else if (wb_en) begin
            dirty_q[wb_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_g) begin
        if (fill_en) begin
            tag_mem[fill_index] <= fill_tag;
            for (int b = 0; b < num_banks; b++) begin
                data_mem[fill_index][b] <= fill_line[b*word_w +: word_w];
            end
        end else if (wb_en) begin
            // Only the addressed bank, byte by byte
            for (int i = 0; i < word_w/byte_w; i++) begin
                if (wb_wstrb[i]) begin
                    data_mem[wb_index][wb_offset[3:2]][i*byte_w +: byte_w] <=
                        wb_wdata[i*byte_w +: byte_w];
                end
            end
        end
    end

    // Synchronous read port
    always_ff @(posedge clk_g) begin
        if (rd_en) begin
            meta.valid <= valid_q[rd_index];
            meta.dirty <= dirty_q[rd_index];
            meta.tag   <= tag_mem[rd_index];
            for (int b = 0; b < num_banks; b++) begin
                line[b*word_w +: word_w] <= data_mem[rd_index][b];
            end
        end
    end

endmodule

//--- hdl/cpu_port.sv
`timescale 1ns/1ps

module cpu_port (
    input  logic                  clk_g,
    input  logic                  resetn,
    input  logic                  valid,
    input  dcache_pkg::cpu_req_t  req,
    output logic                  addr_ok,
    output logic                  data_ok,
    output dcache_pkg::word_t     rdata,
    input  logic                  ctrl_idle,
    input  logic                  refill_done,
    input  dcache_pkg::word_t     refill_word,
    output logic                  lookup_hit,
    output dcache_pkg::cpu_req_t  lookup_req,
    input  dcache_pkg::way_meta_t [dcache_pkg::num_ways-1:0] way_meta,
    input  dcache_pkg::line_t [dcache_pkg::num_ways-1:0]     way_line,
    output dcache_pkg::index_t    rd_index,
    output logic                  rd_en,
    output dcache_pkg::wb_entry_t wb_write,
    output logic                  wb_valid
);
    import dcache_pkg::*;

    logic                lookup_v;
    logic [num_ways-1:0] way_hit;
    line_t               hit_line;
    word_t               hit_word;
    logic                wb_load;

    // A pending store blocks the next request for its cycle
    assign addr_ok  = ctrl_idle && !wb_valid;
    assign rd_en    = valid && addr_ok;
    assign rd_index = req.index;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            lookup_v <= 1'b0;
        end else begin
            lookup_v <= rd_en;
        end
    end

    // Request buffer
    always_ff @(posedge clk_g) begin
        if (rd_en) begin
            lookup_req <= req;
        end
    end

    // Tag compare against the stored metadata of both ways
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = way_meta[w].valid && (way_meta[w].tag == lookup_req.tag);
        end
    end

    assign lookup_hit = |way_hit;

    assign hit_line = way_line[way_hit[1]];
    assign hit_word = hit_line[lookup_req.offset[3:2]*word_w +: word_w];

    // Hits answer in the lookup cycle, misses when the refill lands
    assign data_ok = (lookup_v && lookup_hit) || refill_done;
    assign rdata   = lookup_v ? hit_word : refill_word;

    // Write buffer
    assign wb_load = lookup_v && lookup_hit && lookup_req.op;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= wb_load;
        end
    end

    always_ff @(posedge clk_g) begin
        if (wb_load) begin
            wb_write.way    <= way_hit[1];
            wb_write.index  <= lookup_req.index;
            wb_write.offset <= lookup_req.offset;
            wb_write.wstrb  <= lookup_req.wstrb;
            wb_write.wdata  <= lookup_req.wdata;
        end
    end

endmodule

//--- hdl/miss_ctrl.sv
`timescale 1ns/1ps

module miss_ctrl (
    input  logic                  clk_g,
    input  logic                  resetn,
    input  logic                  accept,
    input  logic                  lookup_hit,
    input  dcache_pkg::cpu_req_t  lookup_req,
    input  dcache_pkg::way_meta_t [dcache_pkg::num_ways-1:0] way_meta,
    input  dcache_pkg::line_t [dcache_pkg::num_ways-1:0]     way_line,
    output logic                  idle,
    output logic                  in_refill,
    input  logic                  wr_rdy,
    input  logic                  rd_rdy,
    output logic                  wr_req,
    output dcache_pkg::mem_wr_t   wr,
    output logic                  rd_req,
    output dcache_pkg::addr_t     rd_addr,
    input  logic                  refill_done,
    output logic                  fill_way
);
    import dcache_pkg::*;

    main_state_t       state;
    main_state_t       next_state;
    logic [lfsr_w-1:0] lfsr_q;
    logic [lfsr_w-1:0] lfsr_d;
    logic              feedback;
    logic              victim_way;
    way_meta_t         vic_meta;
    line_t             vic_line;
    logic              vic_dirty;

    // Victim choice, the lock-up state of all zeros is folded into the loop
    always_comb begin
        feedback  = lfsr_q[7] ^ ~|lfsr_q[6:0];
        lfsr_d    = {lfsr_q[6:4], lfsr_q[3] ^ feedback, lfsr_q[2] ^ feedback,
                     lfsr_q[1] ^ feedback, lfsr_q[0], feedback};
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            lfsr_q     <= '0;
            victim_way <= 1'b0;
        end else begin
            lfsr_q <= lfsr_d;
            if (state == st_idle) begin
                victim_way <= lfsr_q[0];
            end
        end
    end

    // Miss buffer
    always_ff @(posedge clk_g) begin
        if (state == st_lookup && !lookup_hit) begin
            vic_meta <= way_meta[victim_way];
            vic_line <= way_line[victim_way];
        end
    end

    assign vic_dirty = vic_meta.valid && vic_meta.dirty;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    next_state = st_lookup;
                end
            end
            st_lookup: begin
                next_state = lookup_hit ? st_idle : st_miss;
            end
            st_miss: begin
                if (!vic_dirty || wr_rdy) begin
                    next_state = st_replace;
                end
            end
            st_replace: begin
                if (rd_rdy) begin
                    next_state = st_refill;
                end
            end
            st_refill: begin
                if (refill_done) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    // Write-back goes out in the cycle after memory took it
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            wr_req <= 1'b0;
        end else begin
            wr_req <= (state == st_miss) && vic_dirty && wr_rdy;
        end
    end

    assign wr.addr   = {vic_meta.tag, lookup_req.index, 4'b0000};
    assign wr.data   = vic_line;
    assign rd_req    = (state == st_replace);
    assign rd_addr   = {lookup_req.tag, lookup_req.index, 4'b0000};
    assign idle      = (state == st_idle);
    assign in_refill = (state == st_refill);
    assign fill_way  = victim_way;

endmodule

//--- hdl/mem_port.sv
`timescale 1ns/1ps

module mem_port (
    input  logic                 clk_g,
    input  logic                 resetn,
    input  logic                 in_refill,
    input  logic                 ret_valid,
    input  dcache_pkg::word_t    ret_data,
    input  dcache_pkg::cpu_req_t req,
    output logic                 refill_done,
    output dcache_pkg::line_t    fill_line,
    output dcache_pkg::word_t    refill_word
);
    import dcache_pkg::*;

    bank_t beat_cnt;
    line_t line_buf;
    logic  beat;

    assign beat = in_refill && ret_valid;

    // Beat counter, wraps back to bank 0 after the last beat
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (!in_refill) begin
            beat_cnt <= '0;
        end else if (ret_valid) begin
            beat_cnt <= beat_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            refill_done <= 1'b0;
        end else begin
            refill_done <= beat && (beat_cnt == bank_t'(num_banks - 1));
        end
    end

    // Line assembly, bank 0 arrives first
    always_ff @(posedge clk_g) begin
        if (beat) begin
            line_buf[beat_cnt*word_w +: word_w] <= ret_data;
        end
    end

    // Store bytes of a write miss override the refilled bank
    always_comb begin
        fill_line = line_buf;
        if (req.op) begin
            for (int i = 0; i < word_w/byte_w; i++) begin
                if (req.wstrb[i]) begin
                    fill_line[req.offset[3:2]*word_w + i*byte_w +: byte_w] =
                        req.wdata[i*byte_w +: byte_w];
                end
            end
        end
    end

    assign refill_word = fill_line[req.offset[3:2]*word_w +: word_w];

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk_g,
    input  logic                 resetn,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  dcache_pkg::word_t    ret_data,
    output logic                 wr_req,
    output dcache_pkg::mem_wr_t  wr,
    input  logic                 wr_rdy
);
    import dcache_pkg::*;

    logic                       lookup_hit;
    cpu_req_t                   lookup_req;
    way_meta_t [num_ways-1:0]   way_meta;
    line_t [num_ways-1:0]       way_line;
    logic                       ctrl_idle;
    logic                       rd_en;
    index_t                     rd_index;
    wb_entry_t                  wb_write;
    logic                       wb_valid;
    logic                       in_refill;
    logic                       refill_done;
    line_t                      fill_line;
    word_t                      refill_word;
    logic                       fill_way;

    cpu_port u_cpu_port (
        .clk_g       (clk_g),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .ctrl_idle   (ctrl_idle),
        .refill_done (refill_done),
        .refill_word (refill_word),
        .lookup_hit  (lookup_hit),
        .lookup_req  (lookup_req),
        .way_meta    (way_meta),
        .way_line    (way_line),
        .rd_index    (rd_index),
        .rd_en       (rd_en),
        .wb_write    (wb_write),
        .wb_valid    (wb_valid)
    );

    way_store u_way0 (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .meta       (way_meta[0]),
        .line       (way_line[0]),
        .wb_en      (wb_valid && !wb_write.way),
        .wb_index   (wb_write.index),
        .wb_offset  (wb_write.offset),
        .wb_wstrb   (wb_write.wstrb),
        .wb_wdata   (wb_write.wdata),
        .fill_en    (refill_done && !fill_way),
        .fill_index (lookup_req.index),
        .fill_tag   (lookup_req.tag),
        .fill_dirty (lookup_req.op),
        .fill_line  (fill_line)
    );

    way_store u_way1 (
        .clk_g      (clk_g),
        .resetn     (resetn),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .meta       (way_meta[1]),
        .line       (way_line[1]),
        .wb_en      (wb_valid && wb_write.way),
        .wb_index   (wb_write.index),
        .wb_offset  (wb_write.offset),
        .wb_wstrb   (wb_write.wstrb),
        .wb_wdata   (wb_write.wdata),
        .fill_en    (refill_done && fill_way),
        .fill_index (lookup_req.index),
        .fill_tag   (lookup_req.tag),
        .fill_dirty (lookup_req.op),
        .fill_line  (fill_line)
    );

    miss_ctrl u_miss_ctrl (
        .clk_g       (clk_g),
        .resetn      (resetn),
        .accept      (rd_en),
        .lookup_hit  (lookup_hit),
        .lookup_req  (lookup_req),
        .way_meta    (way_meta),
        .way_line    (way_line),
        .idle        (ctrl_idle),
        .in_refill   (in_refill),
        .wr_rdy      (wr_rdy),
        .rd_rdy      (rd_rdy),
        .wr_req      (wr_req),
        .wr          (wr),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .refill_done (refill_done),
        .fill_way    (fill_way)
    );

    mem_port u_mem_port (
        .clk_g       (clk_g),
        .resetn      (resetn),
        .in_refill   (in_refill),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .req         (lookup_req),
        .refill_done (refill_done),
        .fill_line   (fill_line),
        .refill_word (refill_word)
    );

endmodule

//--- test/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                clk_g,
    input  logic                resetn,
    input  logic                stall_en,
    input  logic [31:0]         rnd,
    input  logic                rd_req,
    input  dcache_pkg::addr_t   rd_addr,
    output logic                rd_rdy,
    output logic                ret_valid,
    output dcache_pkg::word_t   ret_data,
    input  logic                wr_req,
    input  dcache_pkg::mem_wr_t wr,
    output logic                wr_rdy
);
    import dcache_pkg::*;

    word_t      mem [addr_t];
    addr_t      line_addr;
    int         beats_left;
    logic [1:0] gap;

    // Unwritten words follow the address pattern
    function automatic word_t read_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    initial begin
        rd_rdy     = 1'b0;
        ret_valid  = 1'b0;
        ret_data   = '0;
        wr_rdy     = 1'b0;
        line_addr  = '0;
        beats_left = 0;
        gap        = 2'b00;
    end

    // Outputs change on the falling edge and are sampled on the rising one
    always @(negedge clk_g) begin
        if (!resetn) begin
            rd_rdy     = 1'b0;
            ret_valid  = 1'b0;
            wr_rdy     = 1'b0;
            beats_left = 0;
            gap        = 2'b00;
        end else begin
            rd_rdy    = 1'b0;
            ret_valid = 1'b0;
            wr_rdy    = !stall_en || (rnd[29:28] == 2'b00);
            if (wr_req) begin
                for (int b = 0; b < num_banks; b++) begin
                    mem[{wr.addr[31:4], 4'h0} | addr_t'(b * 4)] = wr.data[b*32 +: 32];
                end
            end
            if (gap != 2'b00) begin
                gap = gap - 2'd1;
            end else if (beats_left != 0) begin
                ret_valid  = 1'b1;
                ret_data   = read_word(line_addr | addr_t'((num_banks - beats_left) * 4));
                beats_left = beats_left - 1;
                gap        = stall_en ? rnd[31:30] : 2'b00;
            end else if (rd_req && (!stall_en || !rnd[25])) begin
                // Request taken at the next rising edge
                rd_rdy     = 1'b1;
                line_addr  = {rd_addr[31:4], 4'h0};
                beats_left = num_banks;
                gap        = stall_en ? rnd[27:26] : 2'b00;
            end
        end
    end

endmodule

//--- test/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int          clk_period     = 40;
    localparam int          reset_cycles   = 5;
    localparam int          num_accesses   = 400;
    localparam int          access_budget  = 50;
    localparam int          timeout_cycles = num_accesses * access_budget;
    localparam logic [31:0] lcg_seed       = 32'hacdd3b9a;

    logic        clk_g = 1'b0;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    addr_t       rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    word_t       ret_data;
    logic        wr_req;
    mem_wr_t     wr;
    logic        wr_rdy;
    logic        stall_en;
    logic [31:0] stall_rnd = lcg_seed;
    logic [31:0] rand_state;

    word_t       shadow [addr_t];
    string       cur_test;
    int          err_count = 0;
    int          errs_at_start;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          wb_count = 0;
    addr_t       last_wb_addr;
    addr_t       cur_line;
    int          cycle_count;

    always #(clk_period / 2) clk_g = ~clk_g;

    dcache_top u_dut (
        .clk_g     (clk_g),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_rdy    (wr_rdy)
    );

    tb_mem_model u_mem (
        .clk_g     (clk_g),
        .resetn    (resetn),
        .stall_en  (stall_en),
        .rnd       (stall_rnd),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_rdy    (wr_rdy)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk_g) begin
        stall_rnd <= next_rand(stall_rnd);
    end

    function automatic word_t expected_word(input addr_t a);
        addr_t k;
        k = {a[31:2], 2'b00};
        if (shadow.exists(k)) begin
            return shadow[k];
        end
        return k ^ 32'h5a5a0000;
    endfunction

    function automatic line_t expected_line(input addr_t a);
        line_t l;
        for (int b = 0; b < num_banks; b++) begin
            l[b*32 +: 32] = expected_word({a[31:4], 4'h0} | addr_t'(b * 4));
        end
        return l;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wdata, input strb_t wstrb);
        word_t m;
        m = old;
        for (int i = 0; i < 4; i++) begin
            if (wstrb[i]) begin
                m[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return m;
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s: %s", cur_test, what);
        err_count++;
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = err_count;
    endtask

    task automatic finish_test;
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, err_count - errs_at_start);
        end
    endtask

    // Every write-back must carry the current contents of its line
    always @(negedge clk_g) begin
        if (resetn && wr_req) begin
            wb_count++;
            last_wb_addr = wr.addr;
            check_line($sformatf("writeback %h", wr.addr), expected_line(wr.addr), wr.data);
        end
        // A refill fetches the line of the pending access
        if (resetn && rd_req) begin
            check_addr("refill line", cur_line, rd_addr);
        end
    end

    // Runs from one falling edge to another
    // Latency counts cycles from acceptance to data_ok
    task automatic access(input logic op, input addr_t addr, input strb_t wstrb,
                          input word_t wdata, output word_t data, output int lat);
        cur_line = {addr[31:4], 4'h0};
        valid    = 1'b1;
        req      = '{op: op, tag: addr[31:12], index: addr[11:4], offset: addr[3:0],
                     wstrb: wstrb, wdata: wdata};
        while (!addr_ok) begin
            @(negedge clk_g);
        end
        @(negedge clk_g);
        valid = 1'b0;
        lat   = 1;
        while (!data_ok) begin
            @(negedge clk_g);
            lat++;
        end
        data = rdata;
        if (op) begin
            shadow[{addr[31:2], 2'b00}] = merge_bytes(expected_word(addr), wdata, wstrb);
        end else begin
            check_word($sformatf("read %h", addr), expected_word(addr), data);
        end
    endtask

    task automatic test_reset;
        begin_test("reset");
        if (data_ok || rd_req || wr_req) begin
            note_failure("data_ok, rd_req or wr_req active during reset");
        end
        finish_test;
    endtask

    task automatic test_read_miss;
        word_t d;
        int    lat;
        begin_test("read_miss");
        access(1'b0, 32'h0001_2344, 4'h0, 32'h0, d, lat);
        finish_test;
    endtask

    task automatic test_read_hit;
        word_t d;
        int    lat;
        begin_test("read_hit");
        access(1'b0, 32'h0001_2344, 4'h0, 32'h0, d, lat);
        if (lat != 1) begin
            note_failure($sformatf("hit answered after %0d cycles instead of 1", lat));
        end
        finish_test;
    endtask

    task automatic test_write_hit;
        word_t d;
        int    lat;
        begin_test("write_hit");
        access(1'b1, 32'h0001_2348, 4'b0101, 32'hdead_beef, d, lat);
        if (lat != 1) begin
            note_failure($sformatf("write hit completed after %0d cycles instead of 1", lat));
        end
        @(negedge clk_g);
        if (addr_ok) begin
            note_failure("addr_ok high in the cycle the write buffer stores");
        end
        access(1'b0, 32'h0001_2348, 4'h0, 32'h0, d, lat);
        finish_test;
    endtask

    task automatic test_write_miss;
        word_t d;
        int    lat;
        begin_test("write_miss");
        access(1'b1, 32'h0004_5678, 4'b1100, 32'hcafe_1234, d, lat);
        access(1'b0, 32'h0004_5678, 4'h0, 32'h0, d, lat);
        if (lat != 1) begin
            note_failure("line not allocated by the write miss");
        end
        access(1'b0, 32'h0004_5670, 4'h0, 32'h0, d, lat);
        finish_test;
    endtask

    // Keeps adding tags to one set until the dirty line is evicted
    task automatic test_evict;
        addr_t base;
        word_t d;
        int    lat;
        int    wb_before;
        int    used;
        begin_test("evict");
        base      = {20'h00200, 8'h3c, 4'h4};
        wb_before = wb_count;
        access(1'b1, base, 4'hf, 32'h1357_9bdf, d, lat);
        used = 1;
        while (used < 16 && (used < 3 || wb_count == wb_before)) begin
            access(1'b0, {20'h00200 + 20'(used), 8'h3c, 4'h4}, 4'h0, 32'h0, d, lat);
            used++;
        end
        if (wb_count == wb_before) begin
            note_failure($sformatf("no write-back after %0d tags in one set", used));
        end else begin
            check_addr("writeback line", {base[31:4], 4'h0}, last_wb_addr);
        end
        for (int k = 0; k < used; k++) begin
            access(1'b0, {20'h00200 + 20'(k), 8'h3c, 4'h4}, 4'h0, 32'h0, d, lat);
        end
        finish_test;
    endtask

    task automatic test_random;
        logic [31:0] r;
        addr_t       a;
        word_t       d;
        int          lat;
        begin_test("random_stalls");
        stall_en = 1'b1;
        for (int i = 0; i < 200; i++) begin
            rand_state = next_rand(rand_state);
            r          = rand_state;
            a = {20'h00300 + 20'(r[30:28]), 8'h80 + 8'(r[27:26]), r[25:24], 2'b00};
            if (r[31]) begin
                rand_state = next_rand(rand_state);
                access(1'b1, a, r[23:20], rand_state, d, lat);
            end else begin
                access(1'b0, a, 4'h0, 32'h0, d, lat);
            end
        end
        stall_en = 1'b0;
        finish_test;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_g);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        valid      = 1'b0;
        req        = '0;
        resetn     = 1'b0;
        stall_en   = 1'b0;
        rand_state = lcg_seed;
        repeat (reset_cycles) @(negedge clk_g);
        test_reset;
        resetn = 1'b1;
        @(negedge clk_g);
        test_read_miss;
        test_read_hit;
        test_write_hit;
        test_write_miss;
        test_evict;
        test_random;
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb.f
common/dcache_pkg.sv
store/way_store.sv
hdl/cpu_port.sv
hdl/miss_ctrl.sv
hdl/mem_port.sv
hdl/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
